//--- mp_addr_pkg.sv
`include "mp_consts.svh"

package mp_addr_pkg;

  // physical address word.
  // flat is the address as the ports see it.
  // split is how the array decodes it; the bank sits in the
  // low bits so that consecutive words land in different banks.
  typedef union packed {
    logic [`MP_BITADDR-1:0] flat;
    struct packed {
      logic [`MP_BITVROW-1:0] row;
      logic [`MP_BITVBNK-1:0] bank;
    } split;
  } mp_padr_u;

endpackage

//--- mp_bank_array.sv
`include "mp_consts.svh"

module mp_bank_array (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [`MP_NUMWRPT-1:0]                  pwrite,
  input  mp_addr_pkg::mp_padr_u [`MP_NUMWRPT-1:0] pwr_addr,
  input  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   pdin,
  input  logic [`MP_NUMRDPT-1:0]                  pread,
  input  mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] prd_addr,
  output logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0]   t1_dout,
  output logic [`MP_NUMRDPT-1:0]                  rd_vld_bus,
  output mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] rd_padr_bus
);

  import mp_addr_pkg::*;
  import mp_wr_pkg::*;

  logic [`MP_WIDTH-1:0] mem [0:`MP_NUMVBNK-1][0:`MP_NUMVROW-1];

  logic [`MP_NUMWRPT-1:0]              wr_win;
  logic [`MP_NUMWRPT-1:0]              wr_hit;
  logic [`MP_NUMWRPT-1:0][WRIDX_W-1:0] win_idx;

  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] rd_data_q [0:`MP_SRAM_DELAY-1];
  logic [`MP_NUMRDPT-1:0]                rd_vld_q  [0:`MP_SRAM_DELAY-1];
  mp_padr_u [`MP_NUMRDPT-1:0]            rd_padr_q [0:`MP_SRAM_DELAY-1];

  // ============================================================
  // write side.
  // ============================================================
  // only the winning port of a word writes it.
  always_comb begin
    for (int w = 0; w < `MP_NUMWRPT; w++) begin
      wr_hit[w] = mp_last_writer(pwrite, pwr_addr, pwr_addr[w].flat, win_idx[w]);
      wr_win[w] = pwrite[w] & wr_hit[w] & (win_idx[w] == WRIDX_W'(w));
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `MP_NUMWRPT; w++) begin
      if (wr_win[w]) begin
        mem[pwr_addr[w].split.bank][pwr_addr[w].split.row] <= pdin[w];
      end
    end
  end

  // ============================================================
  // read side.
  // ============================================================
  // the first stage samples the word before this edge's writes land.
  always_ff @(posedge clk) begin
    for (int r = 0; r < `MP_NUMRDPT; r++) begin
      rd_data_q[0][r] <= mem[prd_addr[r].split.bank][prd_addr[r].split.row];
    end
    rd_padr_q[0] <= prd_addr;
    for (int i = 1; i < `MP_SRAM_DELAY; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
      rd_padr_q[i] <= rd_padr_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `MP_SRAM_DELAY; i++) begin
        rd_vld_q[i] <= '0;
      end
    end else begin
      rd_vld_q[0] <= pread;
      for (int i = 1; i < `MP_SRAM_DELAY; i++) begin
        rd_vld_q[i] <= rd_vld_q[i-1];
      end
    end
  end

  assign t1_dout     = rd_data_q[`MP_SRAM_DELAY-1];
  assign rd_vld_bus  = rd_vld_q[`MP_SRAM_DELAY-1];
  assign rd_padr_bus = rd_padr_q[`MP_SRAM_DELAY-1];

endmodule

//--- mp_checker.sv
`include "mp_consts.svh"

module mp_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`MP_NUMWRPT-1:0] pwrite,
  input logic [`MP_NUMRDPT-1:0] pread,
  input logic [`MP_NUMRDPT-1:0] iread,
  input logic [`MP_NUMRDPT-1:0] vread_vld,
  input logic [`MP_NUMRDPT-1:0] vread_fwrd
);

  // a read on iread shows up at the outputs this many edges later.
  localparam int RET_DELAY = `MP_SRAM_DELAY + `MP_FLOPOUT;

  int rst_age    = 0;
  int fail_count = 0;

  // the strobe flops clear one edge after the reset synchronizer.
  always @(posedge clk) begin
    if (!rst_n) begin
      if (rst_age < 4) rst_age <= rst_age + 1;
    end else begin
      rst_age <= 0;
    end
  end

  fwrd_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
    (vread_fwrd & ~vread_vld) == '0)
    else begin
      $error("vread_fwrd high without vread_vld");
      fail_count++;
    end

  strobes_in_reset: assert property (@(posedge clk)
    (!rst_n && rst_age >= 2) |-> (pwrite == '0 && pread == '0))
    else begin
      $error("pwrite or pread active during reset");
      fail_count++;
    end

  return_has_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (vread_vld & ~$past(iread, RET_DELAY)) == '0)
    else begin
      $error("read return without a matching read strobe");
      fail_count++;
    end

endmodule

bind mp_core_base mp_checker u_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .pwrite     (pwrite),
  .pread      (pread),
  .iread      (iread),
  .vread_vld  (vread_vld),
  .vread_fwrd (vread_fwrd)
);

//--- mp_consts.svh
`ifndef MP_CONSTS_SVH
`define MP_CONSTS_SVH

// ============================================================
// data and port geometry.
// ============================================================
`define MP_WIDTH       16
`define MP_NUMRDPT     2
`define MP_NUMWRPT     3

// ============================================================
// address geometry.
// ============================================================
`define MP_NUMADDR     64
`define MP_BITADDR     6
`define MP_NUMVBNK     4
`define MP_BITVBNK     2
// rows follow from the word count split over the banks.
`define MP_NUMVROW     (`MP_NUMADDR / `MP_NUMVBNK)
`define MP_BITVROW     4

// ============================================================
// pipeline depths.
// ============================================================
`define MP_FLOPIN      1
`define MP_SRAM_DELAY  2
`define MP_FLOPOUT     1
`define MP_RST_SYNC    3

`endif

//--- mp_core_base.sv
`include "mp_consts.svh"

module mp_core_base (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [`MP_NUMWRPT-1:0]                  iwrite,
  input  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] iwr_addr,
  input  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   idin,
  input  logic [`MP_NUMRDPT-1:0]                  iread,
  input  logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] ird_addr,
  output logic [`MP_NUMWRPT-1:0]                  pwrite,
  output mp_addr_pkg::mp_padr_u [`MP_NUMWRPT-1:0] pwr_addr,
  output logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   pdin,
  output logic [`MP_NUMRDPT-1:0]                  pread,
  output mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] prd_addr,
  input  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0]   t1_dout,
  input  logic [`MP_NUMRDPT-1:0]                  rd_vld_bus,
  input  mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] rd_padr_bus,
  output logic [`MP_NUMRDPT-1:0]                  vread_vld,
  output logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0]   vdout,
  output logic [`MP_NUMRDPT-1:0]                  vread_fwrd,
  output mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] vread_padr
);

  import mp_addr_pkg::*;
  import mp_wr_pkg::*;

  logic [`MP_NUMRDPT-1:0]                fwd_hit;
  logic [`MP_NUMRDPT-1:0][WRIDX_W-1:0]   fwd_idx;
  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] fwd_data;

  logic [`MP_NUMRDPT-1:0]                fwd_flag_q [0:`MP_SRAM_DELAY-1];
  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] fwd_data_q [0:`MP_SRAM_DELAY-1];

  logic [`MP_NUMRDPT-1:0]                ret_vld;
  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] ret_data;
  logic [`MP_NUMRDPT-1:0]                ret_fwrd;

  logic [`MP_NUMRDPT-1:0]                vld_q  [0:`MP_FLOPOUT-1];
  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] data_q [0:`MP_FLOPOUT-1];
  logic [`MP_NUMRDPT-1:0]                fwrd_q [0:`MP_FLOPOUT-1];
  mp_padr_u [`MP_NUMRDPT-1:0]            padr_q [0:`MP_FLOPOUT-1];

  // ============================================================
  // virtual to physical port mapping.
  // ============================================================
  always_comb begin
    pwrite = iwrite;
    pdin   = idin;
    pread  = iread;
    for (int w = 0; w < `MP_NUMWRPT; w++) begin
      pwr_addr[w].flat = iwr_addr[w];
    end
    for (int r = 0; r < `MP_NUMRDPT; r++) begin
      prd_addr[r].flat = ird_addr[r];
    end
  end

  // ============================================================
  // same-cycle forwarding.
  // ============================================================
  // the array reads the old word, so a colliding write is taken from here.
  always_comb begin
    for (int r = 0; r < `MP_NUMRDPT; r++) begin
      fwd_hit[r]  = mp_last_writer(iwrite, iwr_addr, ird_addr[r], fwd_idx[r]) & iread[r];
      fwd_data[r] = idin[fwd_idx[r]];
    end
  end

  // runs alongside the array read delay.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `MP_SRAM_DELAY; i++) begin
        fwd_flag_q[i] <= '0;
      end
    end else begin
      fwd_flag_q[0] <= fwd_hit;
      for (int i = 1; i < `MP_SRAM_DELAY; i++) begin
        fwd_flag_q[i] <= fwd_flag_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    fwd_data_q[0] <= fwd_data;
    for (int i = 1; i < `MP_SRAM_DELAY; i++) begin
      fwd_data_q[i] <= fwd_data_q[i-1];
    end
  end

  // ============================================================
  // return assembly and output flops.
  // ============================================================
  always_comb begin
    ret_vld  = rd_vld_bus;
    ret_fwrd = fwd_flag_q[`MP_SRAM_DELAY-1];
    for (int r = 0; r < `MP_NUMRDPT; r++) begin
      ret_data[r] = ret_fwrd[r] ? fwd_data_q[`MP_SRAM_DELAY-1][r] : t1_dout[r];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `MP_FLOPOUT; i++) begin
        vld_q[i]  <= '0;
        fwrd_q[i] <= '0;
      end
    end else begin
      vld_q[0]  <= ret_vld;
      fwrd_q[0] <= ret_fwrd;
      for (int i = 1; i < `MP_FLOPOUT; i++) begin
        vld_q[i]  <= vld_q[i-1];
        fwrd_q[i] <= fwrd_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    data_q[0] <= ret_data;
    padr_q[0] <= rd_padr_bus;
    for (int i = 1; i < `MP_FLOPOUT; i++) begin
      data_q[i] <= data_q[i-1];
      padr_q[i] <= padr_q[i-1];
    end
  end

  assign vread_vld  = vld_q[`MP_FLOPOUT-1];
  assign vdout      = data_q[`MP_FLOPOUT-1];
  assign vread_fwrd = fwrd_q[`MP_FLOPOUT-1];
  assign vread_padr = padr_q[`MP_FLOPOUT-1];

endmodule

//--- mp_input_stage.sv
`include "mp_consts.svh"

module mp_input_stage (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [`MP_NUMWRPT-1:0]                  vwrite,
  input  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] vwr_addr,
  input  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   vdin,
  input  logic [`MP_NUMRDPT-1:0]                  vread,
  input  logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] vrd_addr,
  output logic                                    ready,
  output logic [`MP_NUMWRPT-1:0]                  iwrite,
  output logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] iwr_addr,
  output logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   idin,
  output logic [`MP_NUMRDPT-1:0]                  iread,
  output logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] ird_addr
);

  logic [`MP_RST_SYNC-1:0] rst_sync;
  logic                    rst_sync_n;

  logic [`MP_NUMWRPT-1:0]                  wr_q    [0:`MP_FLOPIN-1];
  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] waddr_q [0:`MP_FLOPIN-1];
  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   din_q   [0:`MP_FLOPIN-1];
  logic [`MP_NUMRDPT-1:0]                  rd_q    [0:`MP_FLOPIN-1];
  logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] raddr_q [0:`MP_FLOPIN-1];

  // ============================================================
  // reset synchronizer and ready.
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_sync <= '0;
    end else begin
      rst_sync <= {rst_sync[`MP_RST_SYNC-2:0], 1'b1};
    end
  end

  assign rst_sync_n = rst_sync[`MP_RST_SYNC-1];

  // ready trails the synchronized release by one cycle.
  always_ff @(posedge clk) begin
    if (!rst_sync_n) begin
      ready <= 1'b0;
    end else begin
      ready <= 1'b1;
    end
  end

  // ============================================================
  // input flop stage.
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_sync_n) begin
      for (int i = 0; i < `MP_FLOPIN; i++) begin
        wr_q[i] <= '0;
        rd_q[i] <= '0;
      end
    end else begin
      // anything strobed before ready is dropped here.
      wr_q[0] <= vwrite & {`MP_NUMWRPT{ready}};
      rd_q[0] <= vread & {`MP_NUMRDPT{ready}};
      for (int i = 1; i < `MP_FLOPIN; i++) begin
        wr_q[i] <= wr_q[i-1];
        rd_q[i] <= rd_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    waddr_q[0] <= vwr_addr;
    din_q[0]   <= vdin;
    raddr_q[0] <= vrd_addr;
    for (int i = 1; i < `MP_FLOPIN; i++) begin
      waddr_q[i] <= waddr_q[i-1];
      din_q[i]   <= din_q[i-1];
      raddr_q[i] <= raddr_q[i-1];
    end
  end

  assign iwrite   = wr_q[`MP_FLOPIN-1];
  assign iwr_addr = waddr_q[`MP_FLOPIN-1];
  assign idin     = din_q[`MP_FLOPIN-1];
  assign iread    = rd_q[`MP_FLOPIN-1];
  assign ird_addr = raddr_q[`MP_FLOPIN-1];

endmodule

//--- mp_top.sv
`include "mp_consts.svh"

module mp_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [`MP_NUMWRPT-1:0]                  vwrite,
  input  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] vwr_addr,
  input  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   vdin,
  input  logic [`MP_NUMRDPT-1:0]                  vread,
  input  logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] vrd_addr,
  output logic [`MP_NUMRDPT-1:0]                  vread_vld,
  output logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0]   vdout,
  output logic [`MP_NUMRDPT-1:0]                  vread_fwrd,
  output mp_addr_pkg::mp_padr_u [`MP_NUMRDPT-1:0] vread_padr,
  output logic                                    ready
);

  import mp_addr_pkg::*;

  // input stage to core base.
  logic [`MP_NUMWRPT-1:0]                  iwrite;
  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] iwr_addr;
  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0]   idin;
  logic [`MP_NUMRDPT-1:0]                  iread;
  logic [`MP_NUMRDPT-1:0][`MP_BITADDR-1:0] ird_addr;

  // core base to and from the array.
  logic [`MP_NUMWRPT-1:0]                pwrite;
  mp_padr_u [`MP_NUMWRPT-1:0]            pwr_addr;
  logic [`MP_NUMWRPT-1:0][`MP_WIDTH-1:0] pdin;
  logic [`MP_NUMRDPT-1:0]                pread;
  mp_padr_u [`MP_NUMRDPT-1:0]            prd_addr;
  logic [`MP_NUMRDPT-1:0][`MP_WIDTH-1:0] t1_dout;
  logic [`MP_NUMRDPT-1:0]                rd_vld_bus;
  mp_padr_u [`MP_NUMRDPT-1:0]            rd_padr_bus;

  mp_input_stage u_input_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .vwrite   (vwrite),
    .vwr_addr (vwr_addr),
    .vdin     (vdin),
    .vread    (vread),
    .vrd_addr (vrd_addr),
    .ready    (ready),
    .iwrite   (iwrite),
    .iwr_addr (iwr_addr),
    .idin     (idin),
    .iread    (iread),
    .ird_addr (ird_addr)
  );

  mp_core_base u_core_base (
    .clk         (clk),
    .rst_n       (rst_n),
    .iwrite      (iwrite),
    .iwr_addr    (iwr_addr),
    .idin        (idin),
    .iread       (iread),
    .ird_addr    (ird_addr),
    .pwrite      (pwrite),
    .pwr_addr    (pwr_addr),
    .pdin        (pdin),
    .pread       (pread),
    .prd_addr    (prd_addr),
    .t1_dout     (t1_dout),
    .rd_vld_bus  (rd_vld_bus),
    .rd_padr_bus (rd_padr_bus),
    .vread_vld   (vread_vld),
    .vdout       (vdout),
    .vread_fwrd  (vread_fwrd),
    .vread_padr  (vread_padr)
  );

  mp_bank_array u_bank_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .pwrite      (pwrite),
    .pwr_addr    (pwr_addr),
    .pdin        (pdin),
    .pread       (pread),
    .prd_addr    (prd_addr),
    .t1_dout     (t1_dout),
    .rd_vld_bus  (rd_vld_bus),
    .rd_padr_bus (rd_padr_bus)
  );

endmodule

//--- mp_wr_pkg.sv
`include "mp_consts.svh"

package mp_wr_pkg;

  localparam int WRIDX_W = $clog2(`MP_NUMWRPT);

  // looks up which write port owns an address this cycle.
  // returns the hit bit, idx gets the winning port.
  // higher port numbers overwrite lower ones.
  function automatic logic mp_last_writer(
    input  logic [`MP_NUMWRPT-1:0]                  wr,
    input  logic [`MP_NUMWRPT-1:0][`MP_BITADDR-1:0] wr_addr,
    input  logic [`MP_BITADDR-1:0]                  addr,
    output logic [WRIDX_W-1:0]                      idx
  );
    logic hit;
    hit = 1'b0;
    idx = '0;
    for (int w = 0; w < `MP_NUMWRPT; w++) begin
      if (wr[w] && (wr_addr[w] == addr)) begin
        hit = 1'b1;
        idx = WRIDX_W'(w);
      end
    end
    return hit;
  endfunction

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mp_top -o sim_tb

# let assertion errors run on so the testbench reaches its summary.
out=$(./obj_dir/sim_tb +verilator+error+limit+100 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+.
mp_addr_pkg.sv
mp_wr_pkg.sv
mp_input_stage.sv
mp_core_base.sv
mp_bank_array.sv
mp_top.sv
mp_checker.sv
tb_mp_top.sv

//--- tb_mp_top.sv
`include "mp_consts.svh"

module tb_mp_top;

  import mp_addr_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int LATENCY      = 4;
  localparam int MAX_ROWS     = 96;
  localparam int NUM_TESTS    = 6;
  localparam int NW           = `MP_NUMWRPT;
  localparam int NR           = `MP_NUMRDPT;
  localparam int AW           = `MP_BITADDR;
  localparam int BW           = `MP_BITVBNK;
  localparam int DW           = `MP_WIDTH;

  logic                  clk;
  logic                  rst_n;
  logic [NW-1:0]         vwrite;
  logic [NW-1:0][AW-1:0] vwr_addr;
  logic [NW-1:0][DW-1:0] vdin;
  logic [NR-1:0]         vread;
  logic [NR-1:0][AW-1:0] vrd_addr;
  logic [NR-1:0]         vread_vld;
  logic [NR-1:0][DW-1:0] vdout;
  logic [NR-1:0]         vread_fwrd;
  mp_padr_u [NR-1:0]     vread_padr;
  logic                  ready;

  // ============================================================
  // stimulus table, with expected values filled in as rows apply.
  // ============================================================
  int                    row_tid      [0:MAX_ROWS-1];
  logic [NW-1:0]         row_wr       [0:MAX_ROWS-1];
  logic [NW-1:0][AW-1:0] row_waddr    [0:MAX_ROWS-1];
  logic [NW-1:0][DW-1:0] row_wdata    [0:MAX_ROWS-1];
  logic [NR-1:0]         row_rd       [0:MAX_ROWS-1];
  logic [NR-1:0][AW-1:0] row_raddr    [0:MAX_ROWS-1];
  logic [NR-1:0][DW-1:0] row_exp_data [0:MAX_ROWS-1];
  logic [NR-1:0]         row_exp_fwrd [0:MAX_ROWS-1];
  int                    n_rows;

  string test_name [0:NUM_TESTS-1] = '{"reset_ready", "write_read", "write_priority",
                                       "forwarding", "pipelining", "random_fill"};
  int    test_pending [0:NUM_TESTS-1];
  int    test_errors  [0:NUM_TESTS-1];
  int    n_checks;
  int    n_errors;

  logic [DW-1:0] ref_mem [0:`MP_NUMADDR-1];
  int            pipe_row  [$];
  int            pipe_tid  [$];
  int            pipe_step [$];
  integer        seed;

  mp_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .vwrite     (vwrite),
    .vwr_addr   (vwr_addr),
    .vdin       (vdin),
    .vread      (vread),
    .vrd_addr   (vrd_addr),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd),
    .vread_padr (vread_padr),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_plain(input int tid, input string msg);
    $display("%s: %s", test_name[tid], msg);
    test_errors[tid]++;
    n_errors++;
  endtask

  task automatic report_value(input int tid, input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("CHECK FAILED %s %s expected %h actual %h", test_name[tid], what, exp_v, act_v);
    test_errors[tid]++;
    n_errors++;
  endtask

  task automatic add_row(input int tid, input logic [NW-1:0] wr,
                         input logic [AW-1:0] wa0, wa1, wa2,
                         input logic [DW-1:0] wd0, wd1, wd2,
                         input logic [NR-1:0] rd, input logic [AW-1:0] ra0, ra1);
    row_tid[n_rows]   = tid;
    row_wr[n_rows]    = wr;
    row_waddr[n_rows] = {wa2, wa1, wa0};
    row_wdata[n_rows] = {wd2, wd1, wd0};
    row_rd[n_rows]    = rd;
    row_raddr[n_rows] = {ra1, ra0};
    test_pending[tid]++;
    n_rows++;
  endtask

  task automatic build_table();
    logic [AW-1:0] pa [0:4] = '{6'd5, 6'd10, 6'd42, 6'd7, 6'd8};
    logic [NW-1:0] wr;
    logic [31:0]   rnd0;
    logic [31:0]   rnd1;
    seed = 32'h23f3;
    add_row(1, 3'b011, 6'd5, 6'd10, 6'd0, 16'ha5a5, 16'h5a5a, 16'h0, 2'b00, 6'd0, 6'd0);
    add_row(1, 3'b000, 6'd0, 6'd0, 6'd0, 16'h0, 16'h0, 16'h0, 2'b11, 6'd5, 6'd10);
    add_row(1, 3'b000, 6'd0, 6'd0, 6'd0, 16'h0, 16'h0, 16'h0, 2'b11, 6'd10, 6'd5);
    add_row(2, 3'b111, 6'd42, 6'd42, 6'd42, 16'h1111, 16'h2222, 16'h3333, 2'b00, 6'd0, 6'd0);
    add_row(2, 3'b000, 6'd0, 6'd0, 6'd0, 16'h0, 16'h0, 16'h0, 2'b11, 6'd42, 6'd42);
    add_row(3, 3'b011, 6'd7, 6'd8, 6'd0, 16'h0707, 16'h0808, 16'h0, 2'b00, 6'd0, 6'd0);
    add_row(3, 3'b010, 6'd0, 6'd7, 6'd0, 16'h0, 16'h7777, 16'h0, 2'b11, 6'd7, 6'd8);
    add_row(3, 3'b101, 6'd8, 6'd0, 6'd8, 16'h8001, 16'h0, 16'h8003, 2'b11, 6'd8, 6'd7);
    for (int i = 0; i < 8; i++) begin
      add_row(4, 3'b000, 6'd0, 6'd0, 6'd0, 16'h0, 16'h0, 16'h0, 2'b11, pa[i % 5],
              pa[(i + 2) % 5]);
    end
    for (int a = 0; a < `MP_NUMADDR; a += NW) begin
      wr = 3'b111;
      if (a + 1 >= `MP_NUMADDR) wr[1] = 1'b0;
      if (a + 2 >= `MP_NUMADDR) wr[2] = 1'b0;
      rnd0 = $random(seed);
      rnd1 = $random(seed);
      add_row(5, wr, AW'(a), AW'(a + 1), AW'(a + 2), rnd0[15:0], rnd0[31:16], rnd1[15:0],
              2'b00, 6'd0, 6'd0);
    end
    for (int i = 0; i < `MP_NUMADDR / 2; i++) begin
      add_row(5, 3'b000, 6'd0, 6'd0, 6'd0, 16'h0, 16'h0, 16'h0, 2'b11, AW'(2 * i),
              AW'(2 * i + 1));
    end
  endtask

  // ============================================================
  // reference model and checking.
  // ============================================================
  // a same-cycle write wins over the memory, the highest write port last.
  task automatic apply_row(input int s);
    logic          hit;
    logic [DW-1:0] fwd;
    for (int r = 0; r < NR; r++) begin
      hit = 1'b0;
      fwd = '0;
      for (int w = 0; w < NW; w++) begin
        if (row_wr[s][w] && row_waddr[s][w] == row_raddr[s][r]) begin
          hit = 1'b1;
          fwd = row_wdata[s][w];
        end
      end
      row_exp_fwrd[s][r] = hit;
      row_exp_data[s][r] = hit ? fwd : ref_mem[row_raddr[s][r]];
    end
    for (int w = 0; w < NW; w++) begin
      if (row_wr[s][w]) ref_mem[row_waddr[s][w]] = row_wdata[s][w];
    end
    vwrite   = row_wr[s];
    vwr_addr = row_waddr[s];
    vdin     = row_wdata[s];
    vread    = row_rd[s];
    vrd_addr = row_raddr[s];
  endtask

  task automatic check_returns(input int s, input int tid);
    logic [NR-1:0] exp_vld;
    if (s >= 0) exp_vld = row_rd[s];
    else exp_vld = '0;
    for (int r = 0; r < NR; r++) begin
      n_checks++;
      if (vread_vld[r] !== exp_vld[r]) begin
        if (exp_vld[r]) report_plain(tid, $sformatf("read port %0d returned no vread_vld", r));
        else report_plain(tid, $sformatf("vread_vld on read port %0d with no read", r));
      end else if (exp_vld[r]) begin
        if (vdout[r] !== row_exp_data[s][r])
          report_value(tid, $sformatf("vdout[%0d]", r), 32'(row_exp_data[s][r]), 32'(vdout[r]));
        if (vread_fwrd[r] !== row_exp_fwrd[s][r])
          report_value(tid, $sformatf("vread_fwrd[%0d]", r), 32'(row_exp_fwrd[s][r]),
                       32'(vread_fwrd[r]));
        if (vread_padr[r].split.bank !== row_raddr[s][r][BW-1:0])
          report_value(tid, $sformatf("padr bank[%0d]", r), 32'(row_raddr[s][r][BW-1:0]),
                       32'(vread_padr[r].split.bank));
        if (vread_padr[r].split.row !== row_raddr[s][r][AW-1:BW])
          report_value(tid, $sformatf("padr row[%0d]", r), 32'(row_raddr[s][r][AW-1:BW]),
                       32'(vread_padr[r].split.row));
      end
    end
    test_pending[tid]--;
    if (test_pending[tid] == 0)
      $display("test %s: %s, %0d errors", test_name[tid],
               (test_errors[tid] == 0) ? "ok" : "failed", test_errors[tid]);
  endtask

  task automatic check_reset_and_ready();
    int edges;
    // strobes held high through reset must not reach the array.
    vwrite = '1;
    vread  = '1;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      #2;
      if (c >= 2) begin
        n_checks++;
        if (ready !== 1'b0) report_plain(0, "ready is high during reset");
        if (vread_vld !== '0) report_plain(0, "vread_vld is high during reset");
      end
    end
    rst_n  = 1'b1;
    vwrite = '0;
    edges  = 0;
    // reads strobed while ready is low must be dropped.
    while (ready !== 1'b1 && edges < 12) begin
      vread    = '1;
      vrd_addr = {AW'(3), AW'(9)};
      @(posedge clk);
      #2;
      edges++;
    end
    vread = '0;
    n_checks++;
    // seen high after the fourth edge, so the fifth edge samples it high.
    if (ready !== 1'b1) report_plain(0, "ready never rose after reset release");
    else if (edges != 4) report_value(0, "ready rise edge", 32'(4), 32'(edges));
  endtask

  // ============================================================
  // main sequence and watchdog.
  // ============================================================
  initial begin
    rst_n    = 1'b0;
    vwrite   = '0;
    vwr_addr = '0;
    vdin     = '0;
    vread    = '0;
    vrd_addr = '0;
    n_rows   = 0;
    n_checks = 0;
    n_errors = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_pending[t] = 0;
      test_errors[t]  = 0;
    end
    build_table();
    check_reset_and_ready();
    // returns of the dropped reads would surface in these slots.
    for (int k = 0; k < LATENCY; k++) begin
      pipe_row.push_back(-1);
      pipe_tid.push_back(0);
      pipe_step.push_back(k - LATENCY);
      test_pending[0]++;
    end
    for (int s = 0; s < n_rows + LATENCY; s++) begin
      @(posedge clk);
      #2;
      if (pipe_step.size() > 0 && pipe_step[0] == s - LATENCY) begin
        check_returns(pipe_row.pop_front(), pipe_tid.pop_front());
        void'(pipe_step.pop_front());
      end
      if (s < n_rows) begin
        apply_row(s);
        pipe_row.push_back(s);
        pipe_tid.push_back(row_tid[s]);
        pipe_step.push_back(s);
      end else begin
        vwrite = '0;
        vread  = '0;
      end
    end
    if (dut0.u_core_base.u_checker.fail_count != 0) begin
      $display("the checker saw %0d assertion failures", dut0.u_core_base.u_checker.fail_count);
      n_errors += dut0.u_core_base.u_checker.fail_count;
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #1;
    #((n_rows + 20) * CLK_PERIOD * 2);
    $display("watchdog timeout, the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule
